// File: sim.f
ic_pkg.sv
inst_memory.sv
icache.sv
fetch_unit.sv
fetch_top.sv
tb_fetch.sv

// File: run.sh
#!/bin/sh
# Builds the fetch path testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f sim.f -o sim_fetch
output=$(./obj_dir/sim_fetch 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"
then
    exit 0
fi
exit 1

// File: tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

    localparam int                        num_lines   = 16;
    localparam int                        mem_words   = 256;
    localparam int                        mem_latency = 4;
    localparam logic [ic_pkg::addr_w-1:0] reset_pc    = '0;
    localparam int idx_w       = $clog2(num_lines);
    localparam int tag_w       = ic_pkg::addr_w - idx_w - 2;
    localparam int word_w      = $clog2(mem_words);
    localparam int drive_dly   = 2;
    localparam int num_fetches = 161;  // 64 + 16 + 16 + 16 + 1 stale + 8 + 40
    // Preload, reset, a budget per fetch and some slack
    localparam int watchdog_cycles = mem_words + 3 + num_fetches * (mem_latency + 8) + 100;

    logic                      clk;
    logic                      rst;
    logic                      load_valid;
    ic_pkg::load_t             load;
    logic                      redirect_valid;
    logic [ic_pkg::addr_w-1:0] redirect_pc;
    logic                      out_ready;
    logic                      out_valid;
    ic_pkg::fetch_pkt_t        out_pkt;
    logic [15:0]               hit_count;
    logic [15:0]               miss_count;

    logic [ic_pkg::addr_w-1:0] mem_copy [mem_words];
    logic [ic_pkg::addr_w-1:0] exp_pc;
    logic [ic_pkg::addr_w-1:0] exp_instr;
    logic [15:0]               exp_hits;
    logic [15:0]               exp_misses;
    logic [num_lines-1:0]      shadow_valid;
    logic [tag_w-1:0]          shadow_tag [num_lines];
    logic                      fetch_taken;  // The cache accepts a fetch on this edge
    logic [idx_w-1:0]          fetch_idx;
    logic [tag_w-1:0]          fetch_tag;
    logic                      out_fire;
    int                        pkt_count;
    logic [31:0]               rng_state;
    string                     test_name;

    fetch_top #(
        .num_lines   (num_lines),
        .mem_words   (mem_words),
        .mem_latency (mem_latency),
        .reset_pc    (reset_pc)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .load_valid     (load_valid),
        .load           (load),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .out_pkt        (out_pkt),
        .hit_count      (hit_count),
        .miss_count     (miss_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        stop_run();
    endtask

    task automatic check_count(input string name, input logic [15:0] expected,
                               input logic [15:0] delta);
        assert (delta == expected)
        else
            value_error(name, 32'(expected), 32'(delta));
    endtask

    task automatic step();
        @(posedge clk);
        #(drive_dly);
    endtask

    task automatic redirect_to(input logic [ic_pkg::addr_w-1:0] target);
        redirect_valid = 1'b1;
        redirect_pc    = target;
        step();
        redirect_valid = 1'b0;
    endtask

    // Takes n packets and redirects on the edge that takes the last one,
    // so no extra fetch slips into the cache
    task automatic run_pass(input int n, input logic [ic_pkg::addr_w-1:0] next_pc);
        int last;
        last = pkt_count + n - 1;
        while (!(out_valid && pkt_count == last))
            step();
        redirect_to(next_pc);
    endtask

    assign fetch_taken = DUT.req_valid && DUT.req_ready;
    assign fetch_idx   = DUT.req.addr[idx_w+1:2];
    assign fetch_tag   = DUT.req.addr[ic_pkg::addr_w-1:idx_w+2];
    assign out_fire    = out_valid && out_ready;
    assign exp_instr   = mem_copy[exp_pc[word_w+1:2]];

    always @(posedge clk)
    begin
        if (rst)
        begin
            exp_pc       <= reset_pc;
            exp_hits     <= '0;
            exp_misses   <= '0;
            shadow_valid <= '0;
            pkt_count    <= 0;
        end
        else
        begin
            if (out_fire)
            begin
                exp_pc    <= exp_pc + 32'd4;
                pkt_count <= pkt_count + 1;
            end
            if (redirect_valid)
            begin
                exp_pc <= {redirect_pc[ic_pkg::addr_w-1:2], 2'b00};  // Redirect wins
            end
            // Stale fetches still fill their line
            if (fetch_taken)
            begin
                if (shadow_valid[fetch_idx] && shadow_tag[fetch_idx] == fetch_tag)
                begin
                    exp_hits <= exp_hits + 16'd1;
                end
                else
                begin
                    exp_misses              <= exp_misses + 16'd1;
                    shadow_valid[fetch_idx] <= 1'b1;
                    shadow_tag[fetch_idx]   <= fetch_tag;
                end
            end
        end
    end

    pc_follows_rule: assert property (@(posedge clk) disable iff (rst)
        out_fire |-> out_pkt.pc == exp_pc)
    else
        value_error({test_name, ": packet pc"}, $sampled(exp_pc), $sampled(out_pkt.pc));

    instr_matches_memory: assert property (@(posedge clk) disable iff (rst)
        out_fire |-> out_pkt.instr == exp_instr)
    else
        value_error({test_name, ": packet instr"}, $sampled(exp_instr),
                    $sampled(out_pkt.instr));

    hits_match_model: assert property (@(posedge clk) disable iff (rst)
        out_fire |-> hit_count == exp_hits)
    else
        value_error({test_name, ": hit_count"}, 32'($sampled(exp_hits)),
                    32'($sampled(hit_count)));

    misses_match_model: assert property (@(posedge clk) disable iff (rst)
        out_fire |-> miss_count == exp_misses)
    else
        value_error({test_name, ": miss_count"}, 32'($sampled(exp_misses)),
                    32'($sampled(miss_count)));

    packet_held_on_stall: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready && !redirect_valid) |=> (out_valid && $stable(out_pkt)))
    else
    begin
        $display("%s: the packet changed or vanished while the consumer stalled", test_name);
        stop_run();
    end

    reset_clears_state: assert property (@(posedge clk)
        $past(rst) |-> (!out_valid && hit_count == 16'd0 && miss_count == 16'd0))
    else
    begin
        $display("Reset left out_valid high or a counter above zero");
        stop_run();
    end

    initial
    begin
        #(watchdog_cycles * 20);
        $display("Watchdog timeout during %s, packets stopped arriving", test_name);
        stop_run();
    end

    initial
    begin
        logic [15:0] base_hits;
        logic [15:0] base_misses;
        int          target;
        rst            = 1'b1;
        load_valid     = 1'b0;
        load           = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        out_ready      = 1'b0;
        rng_state      = 32'd32;
        test_name      = "reset";

        // Reset stays high while the program goes in, then three clean cycles
        for (int i = 0; i < mem_words; i++)
        begin
            rng_state   = xorshift32(rng_state);
            mem_copy[i] = rng_state;
            load_valid  = 1'b1;
            load.addr   = 32'(i) << 2;
            load.data   = rng_state;
            step();
        end
        load_valid = 1'b0;
        repeat (3) step();
        rst = 1'b0;

        test_name = "sequential fetch";
        out_ready = 1'b1;
        run_pass(64, 32'h100);

        test_name   = "loop first pass";
        base_hits   = hit_count;
        base_misses = miss_count;
        run_pass(16, 32'h100);
        check_count("loop first pass misses", 16'd16, miss_count - base_misses);
        check_count("loop first pass hits", 16'd0, hit_count - base_hits);

        test_name   = "loop second pass";
        base_hits   = hit_count;
        base_misses = miss_count;
        run_pass(16, 32'h200);
        check_count("loop second pass misses", 16'd0, miss_count - base_misses);
        check_count("loop second pass hits", 16'd16, hit_count - base_hits);

        // 0x200 and 0x600 both land on line 0 with different tags
        test_name   = "conflict misses";
        base_hits   = hit_count;
        base_misses = miss_count;
        for (int i = 0; i < 8; i++)
        begin
            run_pass(1, 32'h600);
            run_pass(1, (i == 7) ? 32'h300 : 32'h200);
        end
        check_count("conflict misses", 16'd16, miss_count - base_misses);
        check_count("conflict hits", 16'd0, hit_count - base_hits);

        test_name = "redirect discard";
        while (!DUT.mem_req_valid)
            step();
        redirect_to(32'h0A7);
        while (!out_valid)
            step();
        assert (out_pkt.pc == 32'h0A4)
        else
            value_error("redirect discard first pc", 32'h0A4, out_pkt.pc);
        run_pass(8, 32'h3E0);

        test_name = "back-pressure";
        target    = pkt_count + 40;
        while (pkt_count < target)
        begin
            rng_state = xorshift32(rng_state);
            out_ready = rng_state[7];
            step();
        end
        out_ready = 1'b1;

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int                        num_lines   = 16,
    parameter int                        mem_words   = 256,
    parameter int                        mem_latency = 4,
    parameter logic [ic_pkg::addr_w-1:0] reset_pc    = '0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_valid,
    input  ic_pkg::load_t             load,
    input  logic                      redirect_valid,
    input  logic [ic_pkg::addr_w-1:0] redirect_pc,
    input  logic                      out_ready,
    output logic                      out_valid,
    output ic_pkg::fetch_pkt_t        out_pkt,
    output logic [15:0]               hit_count,
    output logic [15:0]               miss_count
);

    // Fetch unit to cache
    logic               req_valid;
    logic               req_ready;
    ic_pkg::fetch_req_t req;
    logic               rsp_valid;
    logic               rsp_ready;
    ic_pkg::fetch_rsp_t rsp;

    // Cache to memory
    logic                      mem_req_valid;
    logic                      mem_req_ready;
    ic_pkg::mem_req_t          mem_req;
    logic                      mem_rsp_valid;
    logic [ic_pkg::addr_w-1:0] mem_rsp_data;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_valid      (out_valid),
        .out_pkt        (out_pkt),
        .out_ready      (out_ready),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_ready      (rsp_ready)
    );

    icache #(
        .num_lines (num_lines)
    ) u_icache (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .hit_count     (hit_count),
        .miss_count    (miss_count)
    );

    inst_memory #(
        .mem_words   (mem_words),
        .mem_latency (mem_latency)
    ) u_inst_memory (
        .clk           (clk),
        .rst           (rst),
        .load_valid    (load_valid),
        .load          (load),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [ic_pkg::addr_w-1:0] reset_pc = '0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      redirect_valid,
    input  logic [ic_pkg::addr_w-1:0] redirect_pc,
    output logic                      out_valid,
    output ic_pkg::fetch_pkt_t        out_pkt,
    input  logic                      out_ready,
    output logic                      req_valid,
    output ic_pkg::fetch_req_t        req,
    input  logic                      req_ready,
    input  logic                      rsp_valid,
    input  ic_pkg::fetch_rsp_t        rsp,
    output logic                      rsp_ready
);

    logic [ic_pkg::addr_w-1:0] pc;
    logic [ic_pkg::addr_w-1:0] target_pc;
    logic                      need_req;    // A fetch for pc is still owed
    logic                      in_flight;
    logic                      epoch;
    logic                      req_epoch;   // Epoch the outstanding fetch was sent in
    logic                      req_fire;
    logic                      rsp_fire;
    logic                      out_fire;
    logic                      rsp_fresh;

    assign target_pc = {redirect_pc[ic_pkg::addr_w-1:2], 2'b00};

    // Only one fetch at a time, and none while a packet waits on the consumer.
    // The cache is idle whenever this rises, so the request is taken at once
    assign req_valid = need_req && !in_flight && !out_valid;
    assign req.addr  = pc;
    assign rsp_ready = !out_valid;

    assign req_fire  = req_valid && req_ready;
    assign rsp_fire  = rsp_valid && rsp_ready;
    assign out_fire  = out_valid && out_ready;
    assign rsp_fresh = (req_epoch == epoch) && !redirect_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc        <= reset_pc;
            need_req  <= 1'b1;
            in_flight <= 1'b0;
            epoch     <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (req_fire)
            begin
                need_req  <= 1'b0;
                in_flight <= 1'b1;
            end
            if (rsp_fire)
            begin
                in_flight <= 1'b0;
                if (rsp_fresh)
                begin
                    out_valid <= 1'b1;
                end
            end
            if (out_fire)
            begin
                out_valid <= 1'b0;
                need_req  <= 1'b1;
                pc        <= pc + 32'd4;
            end
            // A redirect overrides everything above and flushes the held packet
            if (redirect_valid)
            begin
                epoch     <= ~epoch;
                pc        <= target_pc;
                need_req  <= 1'b1;
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_fire)
        begin
            req_epoch <= epoch;
        end
        if (rsp_fire && rsp_fresh)
        begin
            out_pkt.pc    <= rsp.addr;
            out_pkt.instr <= rsp.data;
        end
    end

endmodule

`default_nettype wire

// File: icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int num_lines = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  ic_pkg::fetch_req_t        req,
    output logic                      req_ready,
    output logic                      rsp_valid,
    output ic_pkg::fetch_rsp_t        rsp,
    input  logic                      rsp_ready,
    output logic                      mem_req_valid,
    output ic_pkg::mem_req_t          mem_req,
    input  logic                      mem_req_ready,
    input  logic                      mem_rsp_valid,
    input  logic [ic_pkg::addr_w-1:0] mem_rsp_data,
    output logic [15:0]               hit_count,
    output logic [15:0]               miss_count
);

    localparam int idx_w = $clog2(num_lines);
    localparam int tag_w = ic_pkg::addr_w - idx_w - 2;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_RESPOND
    } state_t;

    state_t state;
    state_t next_state;

    // One word per line, valid bits are the only reset part
    logic [num_lines-1:0]      line_valid;
    logic [tag_w-1:0]          tag_arr  [num_lines];
    logic [ic_pkg::addr_w-1:0] data_arr [num_lines];

    logic [ic_pkg::addr_w-1:0] req_addr;   // Accepted fetch address
    logic [ic_pkg::addr_w-1:0] rsp_word;
    logic [idx_w-1:0]          line_idx;
    logic [tag_w-1:0]          line_tag;
    logic                      hit;
    logic                      fill_done;

    assign line_idx  = req_addr[idx_w+1:2];
    assign line_tag  = req_addr[ic_pkg::addr_w-1:idx_w+2];
    assign hit       = line_valid[line_idx] && (tag_arr[line_idx] == line_tag);
    assign fill_done = (state == ST_FILL_WAIT) && mem_rsp_valid;

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
            begin
                if (req_valid)
                begin
                    next_state = ST_COMPARE;
                end
            end
            ST_COMPARE:
            begin
                if (hit)
                begin
                    next_state = ST_RESPOND;
                end
                else if (mem_req_ready)
                begin
                    next_state = ST_FILL_WAIT;  // Fill request already taken
                end
                else
                begin
                    next_state = ST_FILL_REQ;
                end
            end
            ST_FILL_REQ:
            begin
                if (mem_req_ready)
                begin
                    next_state = ST_FILL_WAIT;
                end
            end
            ST_FILL_WAIT:
            begin
                if (mem_rsp_valid)
                begin
                    next_state = ST_RESPOND;
                end
            end
            ST_RESPOND:
            begin
                if (rsp_ready)
                begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= ST_IDLE;
            line_valid <= '0;
            hit_count  <= '0;
            miss_count <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == ST_COMPARE)
            begin
                if (hit)
                begin
                    hit_count <= hit_count + 16'd1;
                end
                else
                begin
                    miss_count <= miss_count + 16'd1;
                end
            end
            if (fill_done)
            begin
                line_valid[line_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
        begin
            req_addr <= req.addr;
        end
        if (state == ST_COMPARE && hit)
        begin
            rsp_word <= data_arr[line_idx];
        end
        if (fill_done)
        begin
            tag_arr[line_idx]  <= line_tag;
            data_arr[line_idx] <= mem_rsp_data;
            rsp_word           <= mem_rsp_data;  // Forward the fill word
        end
    end

    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESPOND);
    assign rsp.addr  = req_addr;
    assign rsp.data  = rsp_word;

    // Miss request goes out during the compare cycle already
    assign mem_req_valid = ((state == ST_COMPARE) && !hit) || (state == ST_FILL_REQ);
    assign mem_req.addr  = {req_addr[ic_pkg::addr_w-1:2], 2'b00};

endmodule

`default_nettype wire

// File: inst_memory.sv
`timescale 1ns/1ps
`default_nettype none

module inst_memory #(
    parameter int mem_words   = 256,
    parameter int mem_latency = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_valid,
    input  ic_pkg::load_t             load,
    input  logic                      mem_req_valid,
    input  ic_pkg::mem_req_t          mem_req,
    output logic                      mem_req_ready,
    output logic                      mem_rsp_valid,
    output logic [ic_pkg::addr_w-1:0] mem_rsp_data
);

    localparam int idx_w = $clog2(mem_words);
    localparam int cnt_w = (mem_latency > 1) ? $clog2(mem_latency) : 1;

    logic [ic_pkg::addr_w-1:0] mem_array [mem_words];

    logic [idx_w-1:0] load_idx;
    logic [idx_w-1:0] req_idx;
    logic [idx_w-1:0] rd_idx;     // Word index of the read in progress
    logic [cnt_w-1:0] wait_cnt;
    logic             pending;
    logic             req_fire;

    assign load_idx = load.addr[idx_w+1:2];
    assign req_idx  = mem_req.addr[idx_w+1:2];
    assign req_fire = mem_req_valid && mem_req_ready;

    // Preload port, works regardless of reset
    always_ff @(posedge clk)
    begin
        if (load_valid)
        begin
            mem_array[load_idx] <= load.data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_fire)
        begin
            rd_idx <= req_idx;
        end
    end

    // The counter starts at latency minus one, so the word shows up
    // exactly mem_latency edges after the request was taken
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending  <= 1'b0;
            wait_cnt <= '0;
        end
        else if (req_fire)
        begin
            pending  <= 1'b1;
            wait_cnt <= cnt_w'(mem_latency - 1);
        end
        else if (pending)
        begin
            if (wait_cnt == '0)
            begin
                pending <= 1'b0;  // Response cycle is over
            end
            else
            begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    assign mem_req_ready = !pending;
    assign mem_rsp_valid = pending && (wait_cnt == '0);
    assign mem_rsp_data  = mem_array[rd_idx];  // Read as the counter expires

endmodule

`default_nettype wire

// File: ic_pkg.sv
`default_nettype none

package ic_pkg;

    localparam int addr_w = 32;  // Address and instruction word width

    // Fetch request from the fetch unit, always word aligned
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } fetch_req_t;

    // Cache answer, the address comes back with the word
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] data;
    } fetch_rsp_t;

    // Line fill request from the cache to the instruction memory
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } mem_req_t;

    // Fetch packet handed to the consumer
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] instr;
    } fetch_pkt_t;

    // Preload write into the instruction memory
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] data;
    } load_t;

endpackage

`default_nettype wire
